//--- flist.f
+incdir+logic
logic/de_exec_pkg.sv
logic/de_exec_if.sv
logic/de_cmd_decode.sv
logic/de_line_step.sv
logic/de_blt_step.sv
logic/de_out_merge.sv
logic/de_exec.sv
sim/tb_clkgen.sv
sim/tb_de_exec.sv

//--- Makefile
# Verilator build and run of the execution sequencer testbench
# every variable below can be overridden on the make command line

VERILATOR ?= verilator
TOP       ?= tb_de_exec
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal
PASS_MSG  ?= Test completed successfully

SRCS := $(shell grep -E '\.s?v$$' $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FLIST) $(SRCS) logic/de_exec_defines.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR) -o V$(TOP)

# the log decides pass or fail
run: compile
	-./$(BIN) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "simulation passed" || \
		(echo "simulation FAILED, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- sim/tb_de_exec.sv
// testbench of the drawing engine sequencer with random commands checked against a model
// built and run from the Makefile with tb_de_exec as top
`default_nettype none
`include "de_exec_defines.svh"

module tb_de_exec;
	timeunit 1ns;
	timeprecision 10ps;

	localparam int N_CMD   = 80;
	localparam int MAX_LEN = 12;                     // longest side of a random command
	// worst case per command plus the reset window
	localparam int LIMIT   = N_CMD * (2 * MAX_LEN * MAX_LEN + 10) + 10;

	logic                 de_clk;
	logic                 de_rstn;
	logic                 cmd_load;
	de_exec_pkg::opc_e    opc;
	de_exec_pkg::rop_t    rop;
	logic                 trnsp;
	logic                 solid;
	logic                 sfd;
	logic                 nlst;
	logic [`DE_DIR_W-1:0] dir;
	de_exec_pkg::len_t    len_maj;
	de_exec_pkg::len_t    len_min;
	logic                 next_x;
	logic                 next_y;
	logic                 step_rht;
	logic                 step_dwn;
	logic                 last_pixel;
	logic                 mem_req;
	logic                 mem_rd;
	logic                 mem_rmw;
	logic                 d_chgy;
	logic                 busy;

	// model expectations for the command in flight
	de_exec_pkg::opc_e    exp_kind;                  // LINE, BLT or NOOP class
	logic [`DE_DIR_W-1:0] exp_dir;
	logic                 exp_rmw;
	int exp_x, exp_y, exp_rd, exp_wr, exp_chgy, exp_act, exp_last, exp_row;
	// gathered from the outputs by the monitor
	int n_cyc, n_x, n_y, n_act, n_last, last_at, n_rd, n_wr, n_chgy, n_any;
	int load_cyc, first_cyc, last_cyc, rise_cyc, fall_cyc;
	int cyc_count = 0;
	int k;
	logic mon_on = 1'b0;                             // monitor runs once reset is applied
	logic [31:0] lcg_state;

	tb_clkgen clkgen_i (.de_clk(de_clk), .de_rstn(de_rstn));

	de_exec de_exec_i (.*);

	//////////////////////////////
	// model and random source
	function automatic int unsigned rand_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return {17'd0, lcg_state[30:16]};            // upper bits as the low ones cycle fast
	endfunction

	// minor axis moves over the issued steps
	function automatic int minor_steps(int maj, int min, int steps);
		int err;
		int cnt;
		int i;
		err = maj / 2;
		cnt = 0;
		for (i = 0; i < steps; i++)
		begin
			err = err - min;
			if (err < 0)
			begin
				cnt = cnt + 1;
				err = err + maj;
			end
		end
		return cnt;
	endfunction

	// fetch needed unless source-free rop opaque, solid fill or fetch disabled
	function automatic logic needs_read(de_exec_pkg::rop_t r, logic t, logic s, logic f);
		logic no_src;
		no_src = (r == de_exec_pkg::ROP_CLEAR) || (r == de_exec_pkg::ROP_INVERT) ||
			(r == de_exec_pkg::ROP_SET);
		return !((no_src && !t) || s || f);
	endfunction

	function automatic logic needs_rmw(de_exec_pkg::rop_t r);
		return !(r inside {de_exec_pkg::ROP_CLEAR, de_exec_pkg::ROP_COPY_INV,
			de_exec_pkg::ROP_COPY, de_exec_pkg::ROP_SET});
	endfunction

	//////////////////////////////
	// compare tasks
	task automatic report_fail();
		$display("Test failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_count(string name, de_exec_pkg::len_t exp, de_exec_pkg::len_t act);
		if (act !== exp)
		begin
			$display("ERR %0t %s: expected %0d, actual %0d", $time, name, exp, act);
			report_fail();
		end
	endtask

	task automatic check_flag(string name, logic exp, logic act);
		if (act !== exp)
		begin
			$display("ERR %0t %s: expected %b, actual %b", $time, name, exp, act);
			report_fail();
		end
	endtask

	task automatic check_opc(string name, de_exec_pkg::opc_e exp, de_exec_pkg::opc_e act);
		if (act !== exp)
		begin
			$display("ERR %0t %s: expected %s, actual %s", $time, name, exp.name(), act.name());
			report_fail();
		end
	endtask

	task automatic clear_counts();
		n_x = 0;
		n_y = 0;
		n_act = 0;
		n_last = 0;
		last_at = -1;
		n_rd = 0;
		n_wr = 0;
		n_chgy = 0;
		n_any = 0;
		load_cyc = -1;
		first_cyc = -1;
		last_cyc = -1;
		rise_cyc = -1;
		fall_cyc = -1;
	endtask

	//////////////////////////////
	// random command drives the load strobe and sets the model
	task automatic issue_cmd();
		de_exec_pkg::opc_e    c_opc;
		de_exec_pkg::rop_t    c_rop;
		logic [`DE_DIR_W-1:0] c_dir;
		logic [3:0]           code;
		logic                 c_trnsp;
		logic                 c_solid;
		logic                 c_sfd;
		logic                 c_nlst;
		int                   u;
		int                   maj;
		int                   min;
		int                   steps;
		u = int'(rand_next() % 11);
		code = (u == 0) ? 4'd4 : 4'(u + 5);          // codes with no command behind them
		case (rand_next() % 8)
			0:       c_opc = de_exec_pkg::NOOP;
			1, 2:    c_opc = de_exec_pkg::BLT;
			3, 4:    c_opc = de_exec_pkg::LINE;
			5:       c_opc = de_exec_pkg::ELINE;
			6:       c_opc = de_exec_pkg::P_LINE;
			default: c_opc = de_exec_pkg::opc_e'(code);
		endcase
		maj = 1 + int'(rand_next() % MAX_LEN);
		if (c_opc == de_exec_pkg::BLT)
			min = 1 + int'(rand_next() % MAX_LEN);
		else
			min = 1 + int'(rand_next() % maj);       // line slope at most 1
		c_rop   = de_exec_pkg::rop_t'(rand_next());
		c_dir   = 3'(rand_next());
		c_trnsp = 1'(rand_next());
		c_solid = (rand_next() % 4 == 0);
		c_sfd   = (rand_next() % 4 == 0);
		c_nlst  = (rand_next() % 3 == 0);

		exp_kind = de_exec_pkg::NOOP;
		exp_dir = c_dir;
		exp_rmw = 1'b0;
		exp_x = 0;
		exp_y = 0;
		exp_rd = 0;
		exp_wr = 0;
		exp_chgy = 0;
		exp_act = 0;
		exp_last = 0;
		exp_row = 1;
		if (c_opc inside {de_exec_pkg::LINE, de_exec_pkg::ELINE, de_exec_pkg::P_LINE})
		begin
			steps = (c_nlst || c_opc == de_exec_pkg::ELINE) ? maj - 1 : maj;
			if (steps > 0)                            // one pixel eline draws nothing
			begin
				exp_kind = de_exec_pkg::LINE;
				exp_act = steps;
				exp_last = 1;
				exp_x = c_dir[0] ? steps : minor_steps(maj, min, steps);
				exp_y = c_dir[0] ? minor_steps(maj, min, steps) : steps;
			end
		end
		else if (c_opc == de_exec_pkg::BLT)
		begin
			exp_kind = de_exec_pkg::BLT;
			exp_wr = maj * min;
			exp_rd = needs_read(c_rop, c_trnsp, c_solid, c_sfd) ? maj * min : 0;
			exp_chgy = min;
			exp_act = exp_rd + exp_wr;
			exp_rmw = needs_rmw(c_rop);
			exp_row = maj;
		end

		cmd_load <= 1'b1;
		opc      <= c_opc;
		rop      <= c_rop;
		trnsp    <= c_trnsp;
		solid    <= c_solid;
		sfd      <= c_sfd;
		nlst     <= c_nlst;
		dir      <= c_dir;
		len_maj  <= de_exec_pkg::len_t'(maj);
		len_min  <= de_exec_pkg::len_t'(min);
	endtask

	task automatic compare_results();
		de_exec_pkg::opc_e seen;
		seen = (n_wr != 0) ? de_exec_pkg::BLT :
			(n_act != 0) ? de_exec_pkg::LINE : de_exec_pkg::NOOP;
		check_opc("command class", exp_kind, seen);
		check_count("next_x count", de_exec_pkg::len_t'(exp_x), de_exec_pkg::len_t'(n_x));
		check_count("next_y count", de_exec_pkg::len_t'(exp_y), de_exec_pkg::len_t'(n_y));
		check_count("read cycles", de_exec_pkg::len_t'(exp_rd), de_exec_pkg::len_t'(n_rd));
		check_count("write cycles", de_exec_pkg::len_t'(exp_wr), de_exec_pkg::len_t'(n_wr));
		check_count("d_chgy count", de_exec_pkg::len_t'(exp_chgy), de_exec_pkg::len_t'(n_chgy));
		check_count("last_pixel count", de_exec_pkg::len_t'(exp_last),
			de_exec_pkg::len_t'(n_last));
		if (exp_last != 0)
			check_count("last_pixel step", de_exec_pkg::len_t'(exp_act),
				de_exec_pkg::len_t'(last_at));
		if (exp_kind == de_exec_pkg::NOOP)
			check_count("busy or strobe cycles", '0, de_exec_pkg::len_t'(n_any));
		else
		begin
			check_count("load to first action", 3, de_exec_pkg::len_t'(first_cyc - load_cyc));
			check_count("load to busy", 2, de_exec_pkg::len_t'(rise_cyc - load_cyc));
			check_count("last action to busy low", 1, de_exec_pkg::len_t'(fall_cyc - last_cyc));
			check_count("action span", de_exec_pkg::len_t'(exp_act),
				de_exec_pkg::len_t'(last_cyc - first_cyc + 1));    // no gaps
		end
	endtask

	//////////////////////////////
	// output monitor samples away from the driving edge
	always @(negedge de_clk)
	begin
		if (mon_on)
		begin
			n_cyc = n_cyc + 1;
			if (cmd_load)
				load_cyc = n_cyc;                    // taken on the coming rising edge
			if (busy || next_x || next_y || step_rht || step_dwn || last_pixel ||
				mem_req || mem_rd || mem_rmw || d_chgy)
				n_any = n_any + 1;
			if (busy && rise_cyc < 0)
				rise_cyc = n_cyc;
			if (!busy && rise_cyc >= 0 && fall_cyc < 0)
				fall_cyc = n_cyc;
			if (next_x || next_y || mem_req)         // one action per cycle
			begin
				n_act = n_act + 1;
				if (first_cyc < 0)
					first_cyc = n_cyc;
				last_cyc = n_cyc;
				check_flag("busy", 1'b1, busy);
			end
			if (next_x)
				n_x = n_x + 1;
			if (next_y)
				n_y = n_y + 1;
			if (last_pixel)
			begin
				n_last = n_last + 1;
				last_at = n_act;
			end
			if (mem_rd)
			begin
				n_rd = n_rd + 1;
				check_flag("mem_req", 1'b1, mem_req);
			end
			if (mem_req && !mem_rd)
				n_wr = n_wr + 1;
			if (d_chgy)                              // rides the last write of a row
			begin
				n_chgy = n_chgy + 1;
				check_flag("d_chgy on write", 1'b1, mem_req && !mem_rd);
				check_count("words into row at d_chgy", '0,
					de_exec_pkg::len_t'(n_wr % exp_row));
			end
			check_flag("step_rht", (next_x || next_y) && exp_dir[1], step_rht);
			check_flag("step_dwn", (next_x || next_y) && exp_dir[2], step_dwn);
			check_flag("mem_rmw", mem_req && !mem_rd && exp_rmw, mem_rmw);
		end
	end

	// run limit
	always @(posedge de_clk)
	begin
		cyc_count <= cyc_count + 1;
		if (cyc_count >= LIMIT)
		begin
			$display("timeout: the run did not finish within %0d clock cycles", LIMIT);
			report_fail();
		end
	end

	//////////////////////////////
	// main sequence
	initial
	begin
		lcg_state = 32'd89115;
		n_cyc     = 0;
		cmd_load  = 1'b0;
		opc       = de_exec_pkg::NOOP;
		rop       = '0;
		trnsp     = 1'b0;
		solid     = 1'b0;
		sfd       = 1'b0;
		nlst      = 1'b0;
		dir       = '0;
		len_maj   = de_exec_pkg::len_t'(1);
		len_min   = de_exec_pkg::len_t'(1);
		exp_dir   = '0;
		exp_rmw   = 1'b0;
		exp_row   = 1;
		clear_counts();
		wait (de_rstn === 1'b0);
		mon_on = 1'b1;
		wait (de_rstn === 1'b1);
		clear_counts();
		repeat (4) @(posedge de_clk);
		check_count("strobes before first load", '0, de_exec_pkg::len_t'(n_any));

		for (k = 0; k < N_CMD; k++)
		begin
			@(posedge de_clk);
			clear_counts();
			issue_cmd();
			@(posedge de_clk);
			cmd_load <= 1'b0;
			if (exp_kind == de_exec_pkg::NOOP)
				repeat (6) @(posedge de_clk);       // nothing may start
			else
				while (fall_cyc < 0)
					@(posedge de_clk);
			compare_results();
		end

		$display("Test completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim/tb_clkgen.sv
// clock and reset source for the sequencer testbench
// 20 ns clock, active low reset held over the first edges
`default_nettype none

module tb_clkgen
#(
	parameter int PERIOD  = 20,      // ns
	parameter int RST_CYC = 4
)
(
	output logic de_clk,
	output logic de_rstn
);
	timeunit 1ns;
	timeprecision 10ps;

	initial
	begin
		de_clk = 1'b0;
		forever
			#(PERIOD / 2) de_clk = ~de_clk;
	end

	initial
	begin
		de_rstn = 1'b1;
		#1;
		de_rstn = 1'b0;                  // a real falling edge for the async flops
		repeat (RST_CYC) @(posedge de_clk);
		de_rstn <= 1'b1;
	end

endmodule

`default_nettype wire

//--- logic/de_exec.sv
// drawing engine execution sequencer top, decode -> line/blt engines -> merge
// one command at a time, load only while busy is low
`default_nettype none
`include "de_exec_defines.svh"

module de_exec
(
	input  wire                    de_clk,
	input  wire                    de_rstn,
	input  wire                    cmd_load,
	input  wire de_exec_pkg::opc_e opc,
	input  wire de_exec_pkg::rop_t rop,
	input  wire                    trnsp,
	input  wire                    solid,
	input  wire                    sfd,
	input  wire                    nlst,
	input  wire [`DE_DIR_W-1:0]    dir,
	input  wire de_exec_pkg::len_t len_maj,
	input  wire de_exec_pkg::len_t len_min,
	output logic                   next_x,
	output logic                   next_y,
	output logic                   step_rht,
	output logic                   step_dwn,
	output logic                   last_pixel,
	output logic                   mem_req,
	output logic                   mem_rd,
	output logic                   mem_rmw,
	output logic                   d_chgy,
	output logic                   busy
);

	de_cmd_if  cmd_i ();      // decoded command
	de_step_if line_st ();    // line engine actions
	de_step_if blt_st ();     // blt engine actions

	de_cmd_decode decode_i (.de_clk(de_clk), .de_rstn(de_rstn), .cmd_load(cmd_load),
		.opc(opc), .rop(rop), .trnsp(trnsp), .solid(solid), .sfd(sfd), .nlst(nlst),
		.dir(dir), .len_maj(len_maj), .len_min(len_min), .busy(busy), .cmd(cmd_i.dec));

	// engines run side by side off the same command
	de_line_step line_i (.de_clk(de_clk), .de_rstn(de_rstn), .cmd(cmd_i.eng),
		.step(line_st.src));
	de_blt_step blt_i (.de_clk(de_clk), .de_rstn(de_rstn), .cmd(cmd_i.eng),
		.step(blt_st.src));

	de_out_merge merge_i (.de_clk(de_clk), .de_rstn(de_rstn), .line(line_st.snk),
		.blt(blt_st.snk), .next_x(next_x), .next_y(next_y), .step_rht(step_rht),
		.step_dwn(step_dwn), .last_pixel(last_pixel), .mem_req(mem_req), .mem_rd(mem_rd),
		.mem_rmw(mem_rmw), .d_chgy(d_chgy), .busy(busy));

endmodule

`default_nettype wire

//--- logic/de_out_merge.sv
// last stage, ORs both engines into registered top level outputs
// busy spans the engine cycles and the output register
`default_nettype none

module de_out_merge
(
	input  wire    de_clk,
	input  wire    de_rstn,
	de_step_if.snk line,
	de_step_if.snk blt,
	output logic   next_x,
	output logic   next_y,
	output logic   step_rht,
	output logic   step_dwn,
	output logic   last_pixel,
	output logic   mem_req,
	output logic   mem_rd,
	output logic   mem_rmw,
	output logic   d_chgy,      // destination row change
	output logic   busy
);

	logic pending;              // an action sits in the output registers

	always_ff @(posedge de_clk or negedge de_rstn)
	begin
		if (!de_rstn)
		begin
			next_x     <= 1'b0;
			next_y     <= 1'b0;
			step_rht   <= 1'b0;
			step_dwn   <= 1'b0;
			last_pixel <= 1'b0;
			mem_req    <= 1'b0;
			mem_rd     <= 1'b0;
			mem_rmw    <= 1'b0;
			d_chgy     <= 1'b0;
			pending    <= 1'b0;
		end
		else
		begin
			next_x     <= line.step_x   | blt.step_x;
			next_y     <= line.step_y   | blt.step_y;
			step_rht   <= line.step_rht | blt.step_rht;
			step_dwn   <= line.step_dwn | blt.step_dwn;
			last_pixel <= line.last_pix | blt.last_pix;
			mem_req    <= line.mem_req  | blt.mem_req;
			mem_rd     <= line.mem_rd   | blt.mem_rd;
			mem_rmw    <= line.mem_rmw  | blt.mem_rmw;
			d_chgy     <= line.row_done | blt.row_done;
			pending    <= line.active   | blt.active;
		end
	end

	assign busy = line.active | blt.active | pending;

	// only one engine runs a command at a time
	a_one_engine: assert property (@(posedge de_clk) disable iff (!de_rstn)
		!(line.active && blt.active))
		else $error("line and blt engines active together");

endmodule

`default_nettype wire

//--- logic/de_blt_step.sv
// blt engine walking the words and rows of a rectangle
// issues an optional read then a write per word at one cycle each
`default_nettype none
`include "de_exec_defines.svh"

module de_blt_step
(
	input  wire    de_clk,
	input  wire    de_rstn,
	de_cmd_if.eng  cmd,
	de_step_if.src step
);

	de_exec_pkg::blt_state_e state;       // action on the outputs this cycle
	de_exec_pkg::blt_state_e state_nxt;
	de_exec_pkg::blt_state_e word_first;  // first cycle of each word
	de_exec_pkg::len_t       word;
	de_exec_pkg::len_t       row;
	de_exec_pkg::len_t       maj_m1;
	de_exec_pkg::len_t       min_m1;
	logic                    row_end;     // last write of a row
	logic                    blt_end;     // last write of the blt

	assign maj_m1     = cmd.len_maj - 1'b1;
	assign min_m1     = cmd.len_min - 1'b1;
	assign word_first = cmd.read_need ? de_exec_pkg::B_READ : de_exec_pkg::B_WRITE;
	assign row_end    = (state == de_exec_pkg::B_WRITE) && (word == maj_m1);
	assign blt_end    = row_end && (row == min_m1);

	always_comb
	begin
		case (state)
			de_exec_pkg::B_IDLE:  state_nxt = cmd.go_blt ? word_first : de_exec_pkg::B_IDLE;
			de_exec_pkg::B_READ:  state_nxt = de_exec_pkg::B_WRITE;  // same word
			de_exec_pkg::B_WRITE: state_nxt = blt_end ? de_exec_pkg::B_IDLE : word_first;
			default:              state_nxt = de_exec_pkg::B_IDLE;
		endcase
	end

	always_ff @(posedge de_clk or negedge de_rstn)
	begin
		if (!de_rstn)
		begin
			state <= de_exec_pkg::B_IDLE;
			word  <= '0;
			row   <= '0;
		end
		else
		begin
			state <= state_nxt;
			if (state == de_exec_pkg::B_IDLE)
			begin
				word <= '0;                   // rearm for the next blt
				row  <= '0;
			end
			else if (row_end)
			begin
				word <= '0;
				row  <= row + 1'b1;
			end
			else if (state == de_exec_pkg::B_WRITE)
				word <= word + 1'b1;
		end
	end

	// decoded from the state register
	assign step.mem_req  = (state == de_exec_pkg::B_READ) || (state == de_exec_pkg::B_WRITE);
	assign step.mem_rd   = (state == de_exec_pkg::B_READ);
	assign step.mem_rmw  = (state == de_exec_pkg::B_WRITE) && cmd.rmw;
	assign step.row_done = row_end;
	assign step.active   = (state != de_exec_pkg::B_IDLE);

	// blt never moves the line counters
	assign step.step_x   = 1'b0;
	assign step.step_y   = 1'b0;
	assign step.step_rht = 1'b0;
	assign step.step_dwn = 1'b0;
	assign step.last_pix = 1'b0;

	// a read is always a request and only for fetching commands
	a_rd_req: assert property (@(posedge de_clk) disable iff (!de_rstn)
		step.mem_rd |-> step.mem_req && cmd.read_need)
		else $error("blt read without a request or without read need");

endmodule

`default_nettype wire

//--- logic/de_line_step.sv
// line engine, steps a solid line one pixel per clock
// bresenham error kept locally, registered strobes to the merge stage
`default_nettype none
`include "de_exec_defines.svh"

module de_line_step
(
	input  wire    de_clk,
	input  wire    de_rstn,
	de_cmd_if.eng  cmd,
	de_step_if.src step
);

	de_exec_pkg::line_state_e    state;
	de_exec_pkg::len_t           rem;      // steps still owed after the last issued one
	de_exec_pkg::len_t           n_steps;  // total for this line
	de_exec_pkg::len_t           left;     // owed including the one issued now
	logic signed [`DE_ERR_W-1:0] err;
	logic signed [`DE_ERR_W-1:0] err_cur;
	logic signed [`DE_ERR_W-1:0] err_sub;
	logic signed [`DE_ERR_W-1:0] err_nxt;
	logic                        start;
	logic                        issue;    // a step goes out this clock
	logic                        minor;    // minor axis moves too
	logic                        last;

	assign n_steps = cmd.no_last ? cmd.len_maj - 1'b1 : cmd.len_maj;
	assign start   = (state == de_exec_pkg::L_IDLE) && cmd.go_line && (n_steps != '0);
	assign issue   = start || (state == de_exec_pkg::L_RUN);
	assign left    = start ? n_steps : rem;
	assign last    = (left == de_exec_pkg::len_t'(1));

	// error starts at half the major length
	assign err_cur = start ? $signed({2'b00, cmd.len_maj[`DE_LEN_W-1:1]}) : err;
	assign err_sub = err_cur - $signed({1'b0, cmd.len_min});
	assign minor   = err_sub[`DE_ERR_W-1];                     // went negative
	assign err_nxt = minor ? err_sub + $signed({1'b0, cmd.len_maj}) : err_sub;

	always_ff @(posedge de_clk or negedge de_rstn)
	begin
		if (!de_rstn)
		begin
			state         <= de_exec_pkg::L_IDLE;
			step.step_x   <= 1'b0;
			step.step_y   <= 1'b0;
			step.step_rht <= 1'b0;
			step.step_dwn <= 1'b0;
			step.last_pix <= 1'b0;
			step.active   <= 1'b0;
		end
		else
		begin
			if (issue)
				state <= last ? de_exec_pkg::L_IDLE : de_exec_pkg::L_RUN;
			step.step_x   <= issue && (cmd.dir[0] || minor);   // dir[0] is x major
			step.step_y   <= issue && (!cmd.dir[0] || minor);
			step.step_rht <= issue && cmd.dir[1];
			step.step_dwn <= issue && cmd.dir[2];
			step.last_pix <= issue && last;
			step.active   <= issue;
		end
	end

	// error and count
	always_ff @(posedge de_clk)
	begin
		if (issue)
		begin
			err <= err_nxt;
			rem <= left - 1'b1;
		end
	end

	// no memory traffic from lines
	assign step.mem_req  = 1'b0;
	assign step.mem_rd   = 1'b0;
	assign step.mem_rmw  = 1'b0;
	assign step.row_done = 1'b0;

	// run state always has a step on the outputs
	a_run_step: assert property (@(posedge de_clk) disable iff (!de_rstn)
		(state == de_exec_pkg::L_RUN) |-> (step.step_x || step.step_y))
		else $error("line run cycle without a step");

endmodule

`default_nettype wire

//--- logic/de_cmd_decode.sv
// first stage, latches a host command and classifies opcode and raster op
// issues one go strobe the cycle after cmd_load
`default_nettype none
`include "de_exec_defines.svh"

module de_cmd_decode
(
	input  wire                       de_clk,
	input  wire                       de_rstn,
	input  wire                       cmd_load,  // single-cycle host strobe
	input  wire de_exec_pkg::opc_e    opc,
	input  wire de_exec_pkg::rop_t    rop,
	input  wire                       trnsp,     // transparent
	input  wire                       solid,
	input  wire                       sfd,       // source fetch disable
	input  wire                       nlst,      // no last pixel
	input  wire [`DE_DIR_W-1:0]       dir,
	input  wire de_exec_pkg::len_t    len_maj,
	input  wire de_exec_pkg::len_t    len_min,
	input  wire                       busy,      // fed back from merge
	de_cmd_if.dec                     cmd
);

	logic is_line;   // LINE, ELINE, P_LINE
	logic is_blt;
	logic rop_nosrc; // rop needs no source data

	assign is_line = (opc == de_exec_pkg::LINE) || (opc == de_exec_pkg::ELINE) ||
		(opc == de_exec_pkg::P_LINE);
	assign is_blt  = (opc == de_exec_pkg::BLT);

	assign rop_nosrc = (rop == de_exec_pkg::ROP_CLEAR) || (rop == de_exec_pkg::ROP_INVERT) ||
		(rop == de_exec_pkg::ROP_SET);

	// start strobes, noop and unknown opcodes give none
	always_ff @(posedge de_clk or negedge de_rstn)
	begin
		if (!de_rstn)
		begin
			cmd.go_line <= 1'b0;
			cmd.go_blt  <= 1'b0;
		end
		else
		begin
			cmd.go_line <= cmd_load && is_line;
			cmd.go_blt  <= cmd_load && is_blt;
		end
	end

	// command fields
	always_ff @(posedge de_clk)
	begin
		if (cmd_load)
		begin
			cmd.len_maj   <= len_maj;
			cmd.len_min   <= len_min;
			cmd.dir       <= dir;
			cmd.no_last   <= nlst || (opc == de_exec_pkg::ELINE); // eline never ends on pixel
			cmd.read_need <= !((rop_nosrc && !trnsp) || solid || sfd);
			cmd.rmw       <= !((rop == de_exec_pkg::ROP_CLEAR) ||
				(rop == de_exec_pkg::ROP_COPY_INV) ||
				(rop == de_exec_pkg::ROP_COPY) ||
				(rop == de_exec_pkg::ROP_SET));
		end
	end

	//////////////////////////////
	// load protocol
	a_load_idle: assert property (@(posedge de_clk) disable iff (!de_rstn)
		cmd_load |-> !busy && !cmd.go_line && !cmd.go_blt)
		else $error("command loaded while sequencer busy");

	a_len_nz: assert property (@(posedge de_clk) disable iff (!de_rstn)
		cmd_load && (is_line || is_blt) |-> (len_maj != '0) && (len_min != '0))
		else $error("zero length command");

	a_line_slope: assert property (@(posedge de_clk) disable iff (!de_rstn)
		cmd_load && is_line |-> len_min <= len_maj)
		else $error("line minor length above major");

endmodule

`default_nettype wire

//--- logic/de_exec_if.sv
// bundles passed between the sequencer stages
// plain per-cycle signals, no handshake
`default_nettype none
`include "de_exec_defines.svh"

//////////////////////////////
// decoded command, decode stage to both engines
// fields hold from the go strobe until the next load
interface de_cmd_if;
	logic                 go_line;     // one-cycle start strobes
	logic                 go_blt;
	de_exec_pkg::len_t    len_maj;
	de_exec_pkg::len_t    len_min;
	logic [`DE_DIR_W-1:0] dir;
	logic                 no_last;     // drop final pixel
	logic                 read_need;   // blt fetches before each write
	logic                 rmw;         // write is read-modify-write

	modport dec (output go_line, go_blt, len_maj, len_min, dir, no_last, read_need, rmw);
	modport eng (input  go_line, go_blt, len_maj, len_min, dir, no_last, read_need, rmw);
endinterface

//////////////////////////////
// per engine action outputs, merged in the last stage
interface de_step_if;
	logic step_x;                      // x / y position strobes
	logic step_y;
	logic step_rht;
	logic step_dwn;
	logic last_pix;
	logic mem_req;                     // memory request cycle
	logic mem_rd;
	logic mem_rmw;
	logic row_done;                    // final write of a blt row
	logic active;                      // engine issued an action this cycle

	modport src (output step_x, step_y, step_rht, step_dwn, last_pix,
		mem_req, mem_rd, mem_rmw, row_done, active);
	modport snk (input  step_x, step_y, step_rht, step_dwn, last_pix,
		mem_req, mem_rd, mem_rmw, row_done, active);
endinterface

`default_nettype wire

//--- logic/de_exec_pkg.sv
// shared types of the execution sequencer
// referenced everywhere as de_exec_pkg::name
`default_nettype none
`include "de_exec_defines.svh"

package de_exec_pkg;

	// drawing opcodes, anything not listed is carried but does nothing
	typedef enum logic [`DE_OPC_W-1:0]
	{
		NOOP   = 4'h0,
		BLT    = 4'h1,                  // plain rectangular blt
		LINE   = 4'h2,
		ELINE  = 4'h3,                  // never draws its last pixel
		P_LINE = 4'h5                   // poly line segment
	} opc_e;

	typedef logic [`DE_ROP_W-1:0] rop_t;

	// raster ops with their own read / rmw class
	localparam rop_t ROP_CLEAR    = 4'b0000;
	localparam rop_t ROP_COPY_INV = 4'b0011;
	localparam rop_t ROP_INVERT   = 4'b0101;
	localparam rop_t ROP_COPY     = 4'b1100;
	localparam rop_t ROP_SET      = 4'b1111;

	typedef logic [`DE_LEN_W-1:0] len_t;   // unsigned length

	// line engine
	typedef enum logic [1:0] {L_IDLE, L_RUN} line_state_e;

	// blt engine, one hot
	typedef enum logic [2:0]
	{
		B_IDLE  = 3'b001,
		B_READ  = 3'b010,
		B_WRITE = 3'b100
	} blt_state_e;

endpackage

`default_nettype wire

//--- logic/de_exec_defines.svh
// field widths for the execution sequencer
// include in any RTL or testbench file that sizes a command field
`ifndef DE_EXEC_DEFINES_SVH
`define DE_EXEC_DEFINES_SVH

//////////////////////////////
// command fields
`define DE_LEN_W 10                  // major and minor length fields
`define DE_OPC_W 4                   // drawing opcode
`define DE_ROP_W 4                   // raster op
`define DE_DIR_W 3                   // {down, right, x major}

//////////////////////////////
// derived
`define DE_ERR_W (`DE_LEN_W + 1)     // signed bresenham error, one sign bit over len

`endif
